//--- src/isa_pkg.sv
`default_nettype none

package isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;
  typedef logic [2:0]  funct3_t;

  // major opcodes of the supported subset
  localparam opcode_t OPC_LUI    = 7'b0110111;
  localparam opcode_t OPC_AUIPC  = 7'b0010111;
  localparam opcode_t OPC_OP_IMM = 7'b0010011;
  localparam opcode_t OPC_OP     = 7'b0110011;
  localparam opcode_t OPC_LOAD   = 7'b0000011;
  localparam opcode_t OPC_STORE  = 7'b0100011;

  // funct3 of OP and OP-IMM
  localparam funct3_t F3_ADD  = 3'b000;
  localparam funct3_t F3_SLL  = 3'b001;
  localparam funct3_t F3_SLT  = 3'b010;
  localparam funct3_t F3_SLTU = 3'b011;
  localparam funct3_t F3_XOR  = 3'b100;
  localparam funct3_t F3_SR   = 3'b101;
  localparam funct3_t F3_OR   = 3'b110;
  localparam funct3_t F3_AND  = 3'b111;

  // word width for LW and SW
  localparam funct3_t F3_WORD = 3'b010;

endpackage

`default_nettype wire

//--- src/pipe_pkg.sv
`default_nettype none

package pipe_pkg;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_t;

  // decode to execute
  typedef struct packed {
    logic              valid;
    alu_op_t           alu_op;
    isa_pkg::word_t    op_a;
    isa_pkg::word_t    op_b;
    isa_pkg::word_t    store_data;
    isa_pkg::reg_idx_t rd;
    logic              wen;
    logic              is_load;
    logic              is_store;
  } dec_exe_t;

  // execute to result, result holds the ALU value or the memory address
  typedef struct packed {
    logic              valid;
    isa_pkg::word_t    result;
    isa_pkg::word_t    store_data;
    isa_pkg::reg_idx_t rd;
    logic              wen;
    logic              is_load;
    logic              is_store;
  } exe_res_t;

  // what the hazard unit sees of one downstream stage
  typedef struct packed {
    logic              valid;
    isa_pkg::reg_idx_t rd;
    logic              wen;
    logic              is_load;
    isa_pkg::word_t    data;
  } fwd_src_t;

endpackage

`default_nettype wire

//--- src/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                      i_clock,
  input  wire                      i_reset,
  input  wire isa_pkg::reg_idx_t   i_rs1,
  input  wire isa_pkg::reg_idx_t   i_rs2,
  output isa_pkg::word_t           o_rs1_data,
  output isa_pkg::word_t           o_rs2_data,
  input  wire pipe_pkg::fwd_src_t  i_wr
);

  isa_pkg::word_t regs [32];

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wr.valid && i_wr.wen && i_wr.rd != '0) begin
      regs[i_wr.rd] <= i_wr.data;
    end
  end

  // x0 is hardwired to zero
  assign o_rs1_data = (i_rs1 == '0) ? '0 : regs[i_rs1];
  assign o_rs2_data = (i_rs2 == '0) ? '0 : regs[i_rs2];

endmodule

`default_nettype wire

//--- src/hazard_forward.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_forward (
  input  wire                      i_valid,
  input  wire                      i_use_rs1,
  input  wire                      i_use_rs2,
  input  wire isa_pkg::reg_idx_t   i_rs1,
  input  wire isa_pkg::reg_idx_t   i_rs2,
  input  wire isa_pkg::word_t      i_reg_src1,
  input  wire isa_pkg::word_t      i_reg_src2,
  input  wire pipe_pkg::fwd_src_t  i_exe,
  input  wire pipe_pkg::fwd_src_t  i_res,
  output isa_pkg::word_t           o_src1,
  output isa_pkg::word_t           o_src2,
  output logic                     o_stall
);

  logic exe_writes;
  logic res_writes;
  logic rs1_exe_fwd;
  logic rs2_exe_fwd;
  logic rs1_res_fwd;
  logic rs2_res_fwd;
  logic rs1_load_hit;
  logic rs2_load_hit;

  assign exe_writes = i_exe.valid && i_exe.wen;
  assign res_writes = i_res.valid && i_res.wen;

  // a load in execute has no data yet, only ALU results forward from there
  assign rs1_exe_fwd = i_rs1 != '0 && i_rs1 == i_exe.rd && exe_writes && !i_exe.is_load;
  assign rs2_exe_fwd = i_rs2 != '0 && i_rs2 == i_exe.rd && exe_writes && !i_exe.is_load;
  assign rs1_res_fwd = i_rs1 != '0 && i_rs1 == i_res.rd && res_writes;
  assign rs2_res_fwd = i_rs2 != '0 && i_rs2 == i_res.rd && res_writes;

  assign o_src1 = rs1_exe_fwd ? i_exe.data : rs1_res_fwd ? i_res.data : i_reg_src1;
  assign o_src2 = rs2_exe_fwd ? i_exe.data : rs2_res_fwd ? i_res.data : i_reg_src2;

  assign rs1_load_hit = i_rs1 != '0 && i_rs1 == i_exe.rd && exe_writes && i_exe.is_load;
  assign rs2_load_hit = i_rs2 != '0 && i_rs2 == i_exe.rd && exe_writes && i_exe.is_load;

  // one bubble lets the load reach result, where its data forwards
  assign o_stall = i_valid && ((i_use_rs1 && rs1_load_hit) || (i_use_rs2 && rs2_load_hit));

endmodule

`default_nettype wire

//--- src/decode_stage.sv
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                    i_clock,
  input  wire                    i_reset,
  input  wire                    i_inst_req,
  input  wire isa_pkg::word_t    i_inst,
  output logic                   o_inst_ack,
  input  wire isa_pkg::word_t    i_src1,
  input  wire isa_pkg::word_t    i_src2,
  input  wire                    i_stall,
  output isa_pkg::reg_idx_t      o_rs1,
  output isa_pkg::reg_idx_t      o_rs2,
  output logic                   o_valid,
  output logic                   o_use_rs1,
  output logic                   o_use_rs2,
  output pipe_pkg::dec_exe_t     o_issue
);

  typedef enum logic [1:0] {IDLE, ACK, WAIT_LOW} hs_state_t;

  hs_state_t          state;
  logic               dec_valid;
  isa_pkg::word_t     dec_inst;
  isa_pkg::word_t     dec_pc;
  isa_pkg::word_t     pc;
  logic               issuing;
  logic               capture;
  isa_pkg::opcode_t   opcode;
  isa_pkg::funct3_t   funct3;
  logic               is_op;
  logic               alt;
  isa_pkg::word_t     imm_i;
  isa_pkg::word_t     imm_s;
  isa_pkg::word_t     imm_u;
  pipe_pkg::alu_op_t  arith_op;

  assign issuing = dec_valid && !i_stall;
  // a held instruction blocks capture, so ack stays low
  assign capture = i_inst_req && state == IDLE && (!dec_valid || issuing);
  assign o_inst_ack = state != IDLE;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (capture) begin
            state <= ACK;
          end
        end
        ACK: begin
          if (!i_inst_req) begin
            state <= WAIT_LOW;
          end
        end
        WAIT_LOW: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      dec_valid <= 1'b0;
      pc <= '0;
    end else if (capture) begin
      dec_valid <= 1'b1;
      pc <= pc + 32'd4;
    end else if (issuing) begin
      dec_valid <= 1'b0;
    end
  end

  always_ff @(posedge i_clock) begin
    if (capture) begin
      dec_inst <= i_inst;
      dec_pc <= pc;
    end
  end

  assign opcode = dec_inst[6:0];
  assign funct3 = dec_inst[14:12];
  assign alt = dec_inst[30];
  assign is_op = opcode == isa_pkg::OPC_OP;
  assign imm_i = {{20{dec_inst[31]}}, dec_inst[31:20]};
  assign imm_s = {{20{dec_inst[31]}}, dec_inst[31:25], dec_inst[11:7]};
  assign imm_u = {dec_inst[31:12], 12'b0};

  assign o_rs1 = dec_inst[19:15];
  assign o_rs2 = dec_inst[24:20];
  assign o_valid = dec_valid;
  assign o_use_rs1 = is_op || opcode == isa_pkg::OPC_OP_IMM ||
                     opcode == isa_pkg::OPC_LOAD || opcode == isa_pkg::OPC_STORE;
  assign o_use_rs2 = is_op || opcode == isa_pkg::OPC_STORE;

  // SUB only exists in OP, SRA/SRAI in both
  always_comb begin
    case (funct3)
      isa_pkg::F3_ADD:  arith_op = (is_op && alt) ? pipe_pkg::ALU_SUB : pipe_pkg::ALU_ADD;
      isa_pkg::F3_SLL:  arith_op = pipe_pkg::ALU_SLL;
      isa_pkg::F3_SLT:  arith_op = pipe_pkg::ALU_SLT;
      isa_pkg::F3_SLTU: arith_op = pipe_pkg::ALU_SLTU;
      isa_pkg::F3_XOR:  arith_op = pipe_pkg::ALU_XOR;
      isa_pkg::F3_SR:   arith_op = alt ? pipe_pkg::ALU_SRA : pipe_pkg::ALU_SRL;
      isa_pkg::F3_OR:   arith_op = pipe_pkg::ALU_OR;
      default:          arith_op = pipe_pkg::ALU_AND;
    endcase
  end

  always_comb begin
    o_issue = '0;
    o_issue.valid = issuing;
    o_issue.alu_op = pipe_pkg::ALU_ADD;
    o_issue.rd = dec_inst[11:7];
    case (opcode)
      isa_pkg::OPC_LUI: begin
        o_issue.alu_op = pipe_pkg::ALU_PASS_B;
        o_issue.op_b = imm_u;
        o_issue.wen = 1'b1;
      end
      isa_pkg::OPC_AUIPC: begin
        o_issue.op_a = dec_pc;
        o_issue.op_b = imm_u;
        o_issue.wen = 1'b1;
      end
      isa_pkg::OPC_OP_IMM: begin
        o_issue.alu_op = arith_op;
        o_issue.op_a = i_src1;
        o_issue.op_b = imm_i;
        o_issue.wen = 1'b1;
      end
      isa_pkg::OPC_OP: begin
        o_issue.alu_op = arith_op;
        o_issue.op_a = i_src1;
        o_issue.op_b = i_src2;
        o_issue.wen = 1'b1;
      end
      isa_pkg::OPC_LOAD: begin
        o_issue.op_a = i_src1;
        o_issue.op_b = imm_i;
        o_issue.wen = funct3 == isa_pkg::F3_WORD;
        o_issue.is_load = funct3 == isa_pkg::F3_WORD;
      end
      isa_pkg::OPC_STORE: begin
        o_issue.op_a = i_src1;
        o_issue.op_b = imm_s;
        o_issue.store_data = i_src2;
        o_issue.is_store = funct3 == isa_pkg::F3_WORD;
      end
      // anything else passes through as a no-op
      default: o_issue.wen = 1'b0;
    endcase
  end

endmodule

`default_nettype wire

//--- src/execute_stage.sv
`timescale 1ns/1ps
`default_nettype none

module execute_stage (
  input  wire                      i_clock,
  input  wire                      i_reset,
  input  wire pipe_pkg::dec_exe_t  i_issue,
  output pipe_pkg::exe_res_t       o_exe,
  output pipe_pkg::fwd_src_t       o_fwd
);

  pipe_pkg::dec_exe_t exe_q;
  isa_pkg::word_t     alu_out;
  logic [4:0]         shamt;

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      exe_q <= '0;
    end else begin
      exe_q <= i_issue;
    end
  end

  assign shamt = exe_q.op_b[4:0];

  always_comb begin
    case (exe_q.alu_op)
      pipe_pkg::ALU_ADD:  alu_out = exe_q.op_a + exe_q.op_b;
      pipe_pkg::ALU_SUB:  alu_out = exe_q.op_a - exe_q.op_b;
      pipe_pkg::ALU_SLL:  alu_out = exe_q.op_a << shamt;
      pipe_pkg::ALU_SLT:  alu_out = {31'b0, $signed(exe_q.op_a) < $signed(exe_q.op_b)};
      pipe_pkg::ALU_SLTU: alu_out = {31'b0, exe_q.op_a < exe_q.op_b};
      pipe_pkg::ALU_XOR:  alu_out = exe_q.op_a ^ exe_q.op_b;
      pipe_pkg::ALU_SRL:  alu_out = exe_q.op_a >> shamt;
      pipe_pkg::ALU_SRA:  alu_out = $signed(exe_q.op_a) >>> shamt;
      pipe_pkg::ALU_OR:   alu_out = exe_q.op_a | exe_q.op_b;
      pipe_pkg::ALU_AND:  alu_out = exe_q.op_a & exe_q.op_b;
      default:            alu_out = exe_q.op_b;
    endcase
  end

  // loads and stores use the sum as their address
  always_comb begin
    o_exe.valid = exe_q.valid;
    o_exe.result = alu_out;
    o_exe.store_data = exe_q.store_data;
    o_exe.rd = exe_q.rd;
    o_exe.wen = exe_q.wen;
    o_exe.is_load = exe_q.is_load;
    o_exe.is_store = exe_q.is_store;
  end

  always_comb begin
    o_fwd.valid = exe_q.valid;
    o_fwd.rd = exe_q.rd;
    o_fwd.wen = exe_q.wen;
    o_fwd.is_load = exe_q.is_load;
    o_fwd.data = alu_out;
  end

endmodule

`default_nettype wire

//--- src/result_stage.sv
`timescale 1ns/1ps
`default_nettype none

module result_stage #(
  parameter int MEM_WORDS = 64
) (
  input  wire                      i_clock,
  input  wire                      i_reset,
  input  wire pipe_pkg::exe_res_t  i_exe,
  output pipe_pkg::fwd_src_t       o_wb
);

  localparam int AW = $clog2(MEM_WORDS);

  isa_pkg::word_t     mem [MEM_WORDS];
  pipe_pkg::exe_res_t res_q;
  logic [AW-1:0]      st_idx;
  logic [AW-1:0]      ld_idx;
  isa_pkg::word_t     load_data;

  // word index, upper address bits wrap
  assign st_idx = i_exe.result[AW+1:2];
  assign ld_idx = res_q.result[AW+1:2];

  // store lands as it enters, so a following LW sees it
  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (i_exe.valid && i_exe.is_store) begin
      mem[st_idx] <= i_exe.store_data;
    end
  end

  always_ff @(posedge i_clock) begin
    if (i_reset) begin
      res_q <= '0;
    end else begin
      res_q <= i_exe;
    end
  end

  assign load_data = mem[ld_idx];

  always_comb begin
    o_wb.valid = res_q.valid;
    o_wb.rd = res_q.rd;
    o_wb.wen = res_q.wen;
    o_wb.is_load = res_q.is_load;
    o_wb.data = res_q.is_load ? load_data : res_q.result;
  end

endmodule

`default_nettype wire

//--- src/core_top.sv
`timescale 1ns/1ps
`default_nettype none

module core_top #(
  parameter int MEM_WORDS = 64
) (
  input  wire                   i_clock,
  input  wire                   i_reset,
  input  wire                   i_inst_req,
  input  wire isa_pkg::word_t   i_inst,
  output logic                  o_inst_ack,
  output logic                  o_wb_valid,
  output isa_pkg::reg_idx_t     o_wb_rd,
  output isa_pkg::word_t        o_wb_data
);

  isa_pkg::reg_idx_t  rs1;
  isa_pkg::reg_idx_t  rs2;
  isa_pkg::word_t     reg_src1;
  isa_pkg::word_t     reg_src2;
  isa_pkg::word_t     src1;
  isa_pkg::word_t     src2;
  logic               dec_valid;
  logic               use_rs1;
  logic               use_rs2;
  logic               stall;
  pipe_pkg::dec_exe_t issue;
  pipe_pkg::exe_res_t exe;
  pipe_pkg::fwd_src_t exe_fwd;
  pipe_pkg::fwd_src_t res_fwd;

  decode_stage dec0 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_inst_req(i_inst_req), .i_inst(i_inst), .o_inst_ack(o_inst_ack),
    .i_src1(src1), .i_src2(src2), .i_stall(stall),
    .o_rs1(rs1), .o_rs2(rs2), .o_valid(dec_valid),
    .o_use_rs1(use_rs1), .o_use_rs2(use_rs2), .o_issue(issue)
  );

  hazard_forward hz0 (
    .i_valid(dec_valid), .i_use_rs1(use_rs1), .i_use_rs2(use_rs2),
    .i_rs1(rs1), .i_rs2(rs2), .i_reg_src1(reg_src1), .i_reg_src2(reg_src2),
    .i_exe(exe_fwd), .i_res(res_fwd),
    .o_src1(src1), .o_src2(src2), .o_stall(stall)
  );

  reg_file rf0 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_rs1(rs1), .i_rs2(rs2), .o_rs1_data(reg_src1), .o_rs2_data(reg_src2),
    .i_wr(res_fwd)
  );

  execute_stage exe0 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_issue(issue), .o_exe(exe), .o_fwd(exe_fwd)
  );

  result_stage #(.MEM_WORDS(MEM_WORDS)) res0 (
    .i_clock(i_clock), .i_reset(i_reset),
    .i_exe(exe), .o_wb(res_fwd)
  );

  // x0 writes never show up as retirements
  assign o_wb_valid = res_fwd.valid && res_fwd.wen && res_fwd.rd != '0;
  assign o_wb_rd = res_fwd.rd;
  assign o_wb_data = res_fwd.data;

endmodule

`default_nettype wire

//--- testbench/core_checker.sv
`timescale 1ns/1ps
`default_nettype none

module core_checker #(
  parameter int MEM_WORDS = 64
) (
  input  wire                    i_clock,
  input  wire                    i_reset,
  input  wire                    i_inst_req,
  input  wire                    i_inst_ack,
  input  wire                    i_acc_valid,
  input  wire isa_pkg::word_t    i_acc_inst,
  input  wire                    i_wb_valid,
  input  wire isa_pkg::reg_idx_t i_wb_rd,
  input  wire isa_pkg::word_t    i_wb_data,
  input  wire                    i_done,
  output int                     o_errors,
  output logic                   o_finished
);

  localparam int AW = $clog2(MEM_WORDS);

  typedef struct packed {
    isa_pkg::reg_idx_t rd;
    isa_pkg::word_t    data;
  } wb_exp_t;

  isa_pkg::word_t model_regs [32];
  isa_pkg::word_t model_mem [MEM_WORDS];
  isa_pkg::word_t model_pc;
  wb_exp_t        exp_q [$];
  wb_exp_t        head;
  logic           seen_req;
  logic           ack_q;
  int             wait_cycles;
  int             delayed;
  int             accepted;
  int             retired;

  function automatic isa_pkg::word_t alu_model(input logic [2:0] f3, input logic alt,
                                               input isa_pkg::word_t a,
                                               input isa_pkg::word_t b);
    isa_pkg::word_t r;
    begin
      case (f3)
        3'd0: r = alt ? a - b : a + b;
        3'd1: r = a << b[4:0];
        3'd2: r = {31'b0, $signed(a) < $signed(b)};
        3'd3: r = {31'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (alt) r = $signed(a) >>> b[4:0];
          else r = a >> b[4:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
      return r;
    end
  endfunction

  task automatic execute_model(input isa_pkg::word_t inst);
    isa_pkg::opcode_t  opc;
    isa_pkg::reg_idx_t rd;
    logic [2:0]        f3;
    isa_pkg::word_t    a;
    isa_pkg::word_t    b;
    isa_pkg::word_t    imm_i;
    isa_pkg::word_t    imm_s;
    isa_pkg::word_t    addr;
    isa_pkg::word_t    res;
    logic              writes;
    begin
      opc = inst[6:0];
      rd = inst[11:7];
      f3 = inst[14:12];
      a = model_regs[inst[19:15]];
      b = model_regs[inst[24:20]];
      imm_i = {{20{inst[31]}}, inst[31:20]};
      imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      writes = 1'b1;
      res = '0;
      case (opc)
        isa_pkg::OPC_LUI: res = {inst[31:12], 12'h000};
        isa_pkg::OPC_AUIPC: res = model_pc + {inst[31:12], 12'h000};
        // SRAI is the only OP-IMM that looks at bit 30
        isa_pkg::OPC_OP_IMM: res = alu_model(f3, inst[30] && f3 == 3'd5, a, imm_i);
        isa_pkg::OPC_OP: res = alu_model(f3, inst[30], a, b);
        isa_pkg::OPC_LOAD: begin
          addr = a + imm_i;
          res = model_mem[addr[AW+1:2]];
          writes = f3 == 3'b010;
        end
        isa_pkg::OPC_STORE: begin
          addr = a + imm_s;
          if (f3 == 3'b010) model_mem[addr[AW+1:2]] = b;
          writes = 1'b0;
        end
        default: writes = 1'b0;
      endcase
      if (writes && rd != 5'd0) begin
        model_regs[rd] = res;
        exp_q.push_back({rd, res});
      end
      model_pc = model_pc + 32'd4;
    end
  endtask

  always @(posedge i_clock) begin
    if (i_reset) begin
      model_regs = '{default: '0};
      model_mem = '{default: '0};
      model_pc = '0;
      exp_q.delete();
      o_errors = 0;
      o_finished = 1'b0;
      seen_req = 1'b0;
      ack_q = 1'b0;
      wait_cycles = 0;
      delayed = 0;
      accepted = 0;
      retired = 0;
    end else begin
      if (!seen_req && (i_inst_ack || i_wb_valid)) begin
        o_errors++;
        $display("ack or write-back was active before the first request");
      end
      if (i_inst_req) seen_req = 1'b1;
      // a held decode register shows up as an ack that takes longer
      if (i_inst_req && !i_inst_ack) wait_cycles++;
      if (i_inst_ack && !ack_q) begin
        if (wait_cycles > 1) delayed++;
        wait_cycles = 0;
      end
      ack_q = i_inst_ack;
      if (i_wb_valid) begin
        retired++;
        if (exp_q.size() == 0) begin
          o_errors++;
          $display("write-back to x%0d arrived with no write pending", i_wb_rd);
        end else begin
          head = exp_q.pop_front();
          if (i_wb_rd !== head.rd) begin
            o_errors++;
            $display("** Error o_wb_rd exp %h got %h", head.rd, i_wb_rd);
          end
          if (i_wb_data !== head.data) begin
            o_errors++;
            $display("** Error o_wb_data exp %h got %h", head.data, i_wb_data);
          end
        end
      end
      if (i_acc_valid) begin
        accepted++;
        execute_model(i_acc_inst);
      end
      if (i_done && !o_finished) begin
        if (exp_q.size() != 0) begin
          o_errors += exp_q.size();
          $display("%0d expected write-backs never retired", exp_q.size());
        end
        $display("checker: %0d errors, %0d accepted, %0d retired, %0d delayed acks",
                 o_errors, accepted, retired, delayed);
        o_finished = 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- testbench/tb_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_core;

  localparam int MEM_WORDS = 64;
  localparam int NUM_INSTS = 400;
  localparam int CYCLE_LIMIT = NUM_INSTS * 8 + 50;

  logic              clock;
  logic              reset;
  logic              inst_req;
  isa_pkg::word_t    inst;
  logic              inst_ack;
  logic              wb_valid;
  isa_pkg::reg_idx_t wb_rd;
  isa_pkg::word_t    wb_data;
  logic              acc_valid;
  isa_pkg::word_t    acc_inst;
  logic              done;
  int                errors;
  logic              finished;
  int                cycles = 0;

  core_top #(.MEM_WORDS(MEM_WORDS)) dut0 (
    .i_clock(clock), .i_reset(reset),
    .i_inst_req(inst_req), .i_inst(inst), .o_inst_ack(inst_ack),
    .o_wb_valid(wb_valid), .o_wb_rd(wb_rd), .o_wb_data(wb_data)
  );

  core_checker #(.MEM_WORDS(MEM_WORDS)) chk0 (
    .i_clock(clock), .i_reset(reset),
    .i_inst_req(inst_req), .i_inst_ack(inst_ack),
    .i_acc_valid(acc_valid), .i_acc_inst(acc_inst),
    .i_wb_valid(wb_valid), .i_wb_rd(wb_rd), .i_wb_data(wb_data),
    .i_done(done), .o_errors(errors), .o_finished(finished)
  );

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  // mostly x0..x7 so that neighbours share registers
  function automatic isa_pkg::reg_idx_t pick_reg();
    logic [31:0] r;
    begin
      r = $urandom();
      if (r[3:0] < 4'd14) return {2'b00, r[6:4]};
      return r[8:4];
    end
  endfunction

  function automatic isa_pkg::word_t random_inst();
    int unsigned       sel;
    logic [31:0]       r;
    logic [2:0]        f3;
    logic [11:0]       imm;
    logic [6:0]        f7;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs1;
    isa_pkg::reg_idx_t rs2;
    begin
      sel = $urandom_range(99, 0);
      r = $urandom();
      f3 = r[2:0];
      imm = r[14:3];
      f7 = {1'b0, r[15], 5'b00000};
      rd = pick_reg();
      rs1 = pick_reg();
      rs2 = pick_reg();
      if (sel < 25) begin
        if (f3 != 3'd0 && f3 != 3'd5) f7 = 7'h00;
        return {f7, rs2, rs1, f3, rd, isa_pkg::OPC_OP};
      end
      if (sel < 50) begin
        if (f3 == 3'd1) imm[11:5] = 7'h00;
        if (f3 == 3'd5) imm[11:5] = f7;
        return {imm, rs1, f3, rd, isa_pkg::OPC_OP_IMM};
      end
      if (sel < 60) return {r[31:12], rd, isa_pkg::OPC_LUI};
      if (sel < 66) return {r[31:12], rd, isa_pkg::OPC_AUIPC};
      // small word offsets from x0 so stores and loads meet often
      imm = {6'b000000, r[19:16], 2'b00};
      if (sel < 80) return {imm, 5'd0, 3'b010, rd, isa_pkg::OPC_LOAD};
      if (sel < 95) return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], isa_pkg::OPC_STORE};
      // branch opcode, outside the subset
      return {r[31:7], 7'b1100011};
    end
  endfunction

  // four-phase request, called just after a rising edge
  task automatic send_inst(input isa_pkg::word_t word);
    begin
      inst = word;
      inst_req = 1'b1;
      @(posedge clock);
      #1;
      while (!inst_ack) begin
        @(posedge clock);
        #1;
      end
      inst_req = 1'b0;
      acc_valid = 1'b1;
      acc_inst = word;
      @(posedge clock);
      #1;
      acc_valid = 1'b0;
      while (inst_ack) begin
        @(posedge clock);
        #1;
      end
    end
  endtask

  initial begin
    void'($urandom(32'h04a5_bd20));
    reset = 1'b1;
    inst_req = 1'b0;
    inst = '0;
    acc_valid = 1'b0;
    acc_inst = '0;
    done = 1'b0;
    repeat (2) @(posedge clock);
    #1;
    reset = 1'b0;
    // quiet cycles before the first request
    repeat (3) @(posedge clock);
    #1;
    for (int n = 0; n < NUM_INSTS; n++) begin
      send_inst(random_inst());
    end
    repeat (10) @(posedge clock);
    #1;
    done = 1'b1;
    while (finished !== 1'b1) begin
      @(posedge clock);
      #1;
    end
    if (errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/isa_pkg.sv
src/pipe_pkg.sv
src/reg_file.sv
src/hazard_forward.sv
src/decode_stage.sv
src/execute_stage.sv
src/result_stage.sv
src/core_top.sv
testbench/core_checker.sv
testbench/tb_core.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module tb_core -f filelist.f &&
./obj_dir/Vtb_core | tee /dev/stderr | grep -x "sim passed" > /dev/null &&
exit 0 || exit 1
